// File: rtl/data_access_pkg.sv
`default_nettype none

package data_access_pkg;

	localparam int data_w      = 32;
	localparam int reg_addr_w  = 5;
	localparam int queue_depth = 4;
	localparam int queue_ptr_w = $clog2(queue_depth);

	// sram-like size codes
	localparam logic [1:0] size_byte = 2'd0;
	localparam logic [1:0] size_half = 2'd1;
	localparam logic [1:0] size_word = 2'd2;

	typedef enum logic [2:0] {
		op_lb,
		op_lbu,
		op_lh,
		op_lhu,
		op_lw,
		op_sb,
		op_sh,
		op_sw
	} mem_op_e;

	// cp0 cause codes for address errors
	typedef enum logic [4:0] {
		exc_adel = 5'd4,
		exc_ades = 5'd5
	} exc_code_e;

	typedef struct packed {
		mem_op_e               op;
		logic [data_w-1:0]     addr;
		logic [data_w-1:0]     wdata;
		logic [reg_addr_w-1:0] wreg;
	} mem_cmd_t;

	typedef struct packed {
		mem_op_e               op;
		logic [data_w-1:0]     addr;
		logic [1:0]            size;
		logic [data_w-1:0]     wdata;
		logic [reg_addr_w-1:0] wreg;
	} mem_req_t;

	typedef struct packed {
		logic [reg_addr_w-1:0] wreg;
		logic [data_w-1:0]     data;
	} wb_t;

	typedef struct packed {
		exc_code_e             code;
		logic [data_w-1:0]     badvaddr;
		logic [reg_addr_w-1:0] wreg;
	} exc_t;

	function automatic logic op_is_store(mem_op_e op);
		return op inside {op_sb, op_sh, op_sw};
	endfunction

endpackage

`default_nettype wire

// File: rtl/mem_op_issue.sv
`timescale 1ns/10ps
`default_nettype none

module mem_op_issue (
	input  wire logic                       clk,
	input  wire logic                       reset,
	input  wire logic                       cmd_valid,
	input  wire data_access_pkg::mem_cmd_t  cmd,
	input  wire logic                       full,
	output logic                            cmd_allowin,
	output logic                            push,
	output data_access_pkg::mem_req_t       push_req,
	output logic                            exc_valid,
	output data_access_pkg::exc_t           exc
);

	import data_access_pkg::*;

	logic       item_valid;
	mem_cmd_t   item;
	logic       is_store;
	logic       misaligned;
	logic       item_leaves;
	logic [1:0] size;

	////////////////////////////////////////////////////////////////////////////
	// command register

	always_ff @(posedge clk) begin
		if (reset) begin
			item_valid <= 1'b0;
		end else if (cmd_allowin) begin
			item_valid <= cmd_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_valid && cmd_allowin) begin
			item <= cmd;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// alignment check and size code

	always_comb begin
		size       = size_word;
		misaligned = 1'b0;
		unique case (item.op)
			op_lb, op_lbu, op_sb: size = size_byte;
			op_lh, op_lhu, op_sh: begin
				size       = size_half;
				misaligned = item.addr[0];
			end
			op_lw, op_sw: misaligned = item.addr[1:0] != 2'b00;
		endcase
	end

	assign is_store = op_is_store(item.op);

	// exceptions never wait for queue room
	assign exc_valid   = item_valid & misaligned;
	assign push        = item_valid & ~misaligned & ~full;
	assign item_leaves = exc_valid | push;
	assign cmd_allowin = ~item_valid | item_leaves;

	always_comb begin
		push_req.op    = item.op;
		push_req.addr  = item.addr;
		push_req.size  = size;
		// move store data onto its byte lane
		push_req.wdata = item.wdata << {item.addr[1:0], 3'b000};
		push_req.wreg  = item.wreg;
	end

	always_comb begin
		exc.code     = is_store ? exc_ades : exc_adel;
		exc.badvaddr = item.addr;
		exc.wreg     = item.wreg;
	end

endmodule

`default_nettype wire

// File: rtl/mem_req_queue.sv
`timescale 1ns/10ps
`default_nettype none

module mem_req_queue (
	input  wire logic                       clk,
	input  wire logic                       reset,
	input  wire logic                       push,
	input  wire data_access_pkg::mem_req_t  push_req,
	input  wire logic                       pop,
	output logic                            full,
	output logic                            head_valid,
	output data_access_pkg::mem_req_t       head
);

	import data_access_pkg::*;

	logic [queue_ptr_w-1:0] rd_ptr;
	logic [queue_ptr_w-1:0] wr_ptr;
	logic [queue_ptr_w:0]   count;
	mem_req_t               entries [queue_depth];
	logic                   do_push;
	logic                   do_pop;

	function automatic logic [queue_ptr_w-1:0] next_ptr(logic [queue_ptr_w-1:0] ptr);
		if (ptr == queue_ptr_w'(queue_depth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full       = count == (queue_ptr_w + 1)'(queue_depth);
	assign head_valid = count != '0;
	assign head       = entries[rd_ptr];

	assign do_push = push & ~full;
	assign do_pop  = pop & head_valid;

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			// simultaneous push and pop keeps the count
			unique case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			entries[wr_ptr] <= push_req;
		end
	end

endmodule

`default_nettype wire

// File: rtl/sram_data_master.sv
`timescale 1ns/10ps
`default_nettype none

module sram_data_master (
	input  wire logic                                 clk,
	input  wire logic                                 reset,
	input  wire logic                                 head_valid,
	input  wire data_access_pkg::mem_req_t            head,
	input  wire logic [data_access_pkg::data_w-1:0]   data_rdata,
	input  wire logic                                 data_addr_ok,
	input  wire logic                                 data_data_ok,
	output logic                                      pop,
	output logic                                      data_req,
	output logic                                      data_wr,
	output logic [1:0]                                data_size,
	output logic [data_access_pkg::data_w-1:0]        data_addr,
	output logic [data_access_pkg::data_w-1:0]        data_wdata,
	output logic                                      wb_valid,
	output data_access_pkg::wb_t                      wb
);

	import data_access_pkg::*;

	logic              wait_flag;
	logic              addr_acc;
	logic              busy;
	logic [data_w-1:0] rdata_sh;
	logic [data_w-1:0] load_data;

	////////////////////////////////////////////////////////////////////////////
	// sram-like request side

	// no new request while one is outstanding
	assign data_req = head_valid & ~wait_flag;
	assign addr_acc = data_req & data_addr_ok;
	assign busy     = wait_flag | addr_acc;
	assign pop      = busy & data_data_ok;

	assign data_wr    = op_is_store(head.op);
	assign data_size  = head.size;
	assign data_addr  = head.addr;
	assign data_wdata = head.wdata;

	always_ff @(posedge clk) begin
		if (reset) begin
			wait_flag <= 1'b0;
		end else if (pop) begin
			wait_flag <= 1'b0;
		end else if (addr_acc) begin
			wait_flag <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// load data extension

	// addressed byte or half down to bit 0
	assign rdata_sh = data_rdata >> {head.addr[1:0], 3'b000};

	always_comb begin
		unique case (head.op)
			op_lb:   load_data = {{(data_w - 8){rdata_sh[7]}}, rdata_sh[7:0]};
			op_lbu:  load_data = {{(data_w - 8){1'b0}}, rdata_sh[7:0]};
			op_lh:   load_data = {{(data_w - 16){rdata_sh[15]}}, rdata_sh[15:0]};
			op_lhu:  load_data = {{(data_w - 16){1'b0}}, rdata_sh[15:0]};
			default: load_data = data_rdata;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= pop & ~data_wr;
		end
	end

	always_ff @(posedge clk) begin
		if (pop && !data_wr) begin
			wb.wreg <= head.wreg;
			wb.data <= load_data;
		end
	end

endmodule

`default_nettype wire

// File: rtl/data_access_unit.sv
`timescale 1ns/10ps
`default_nettype none

module data_access_unit (
	input  wire logic                                 clk,
	input  wire logic                                 reset,
	input  wire logic                                 cmd_valid,
	input  wire data_access_pkg::mem_cmd_t            cmd,
	output logic                                      cmd_allowin,
	output logic                                      exc_valid,
	output data_access_pkg::exc_t                     exc,
	output logic                                      wb_valid,
	output data_access_pkg::wb_t                      wb,
	output logic                                      data_req,
	output logic                                      data_wr,
	output logic [1:0]                                data_size,
	output logic [data_access_pkg::data_w-1:0]        data_addr,
	output logic [data_access_pkg::data_w-1:0]        data_wdata,
	input  wire logic [data_access_pkg::data_w-1:0]   data_rdata,
	input  wire logic                                 data_addr_ok,
	input  wire logic                                 data_data_ok
);

	import data_access_pkg::*;

	logic     push;
	mem_req_t push_req;
	logic     full;
	logic     head_valid;
	mem_req_t head;
	logic     pop;

	// alignment check and request build
	mem_op_issue i_mem_op_issue (
		.clk         (clk),
		.reset       (reset),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd),
		.full        (full),
		.cmd_allowin (cmd_allowin),
		.push        (push),
		.push_req    (push_req),
		.exc_valid   (exc_valid),
		.exc         (exc)
	);

	mem_req_queue i_mem_req_queue (
		.clk        (clk),
		.reset      (reset),
		.push       (push),
		.push_req   (push_req),
		.pop        (pop),
		.full       (full),
		.head_valid (head_valid),
		.head       (head)
	);

	sram_data_master i_sram_data_master (
		.clk          (clk),
		.reset        (reset),
		.head_valid   (head_valid),
		.head         (head),
		.data_rdata   (data_rdata),
		.data_addr_ok (data_addr_ok),
		.data_data_ok (data_data_ok),
		.pop          (pop),
		.data_req     (data_req),
		.data_wr      (data_wr),
		.data_size    (data_size),
		.data_addr    (data_addr),
		.data_wdata   (data_wdata),
		.wb_valid     (wb_valid),
		.wb           (wb)
	);

endmodule

`default_nettype wire

// File: bench/sram_data_model.sv
`timescale 1ns/10ps
`default_nettype none

module sram_data_model (
	input  wire logic                               clk,
	input  wire logic                               reset,
	input  wire logic                               data_req,
	input  wire logic                               data_wr,
	input  wire logic [1:0]                         data_size,
	input  wire logic [data_access_pkg::data_w-1:0] data_addr,
	input  wire logic [data_access_pkg::data_w-1:0] data_wdata,
	output logic [data_access_pkg::data_w-1:0]      data_rdata,
	output logic                                    data_addr_ok,
	output logic                                    data_data_ok
);

	import data_access_pkg::*;

	logic [data_w-1:0] mem [256];
	logic [31:0]       rng;
	logic [1:0]        addr_wait;
	logic [1:0]        data_wait;
	logic              pending;
	logic [7:0]        idx;

	function automatic logic [31:0] xorshift32(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	initial begin
		data_rdata = '0;
		for (int i = 0; i < 256; i++) begin
			mem[i] = i * 32'h01010101;
		end
	end

	assign idx          = data_addr[9:2];
	assign data_addr_ok = data_req & ~pending & (addr_wait == 2'd0);
	assign data_data_ok = pending & (data_wait == 2'd0);

	// one draw per accepted request sets both delays
	always_ff @(posedge clk) begin
		if (reset) begin
			pending   <= 1'b0;
			rng       <= 32'd35436;
			addr_wait <= 2'd1;
			data_wait <= 2'd0;
		end else if (data_addr_ok) begin
			pending   <= 1'b1;
			data_wait <= rng[1:0];
			addr_wait <= rng[5:4];
			rng       <= xorshift32(rng);
		end else if (data_data_ok) begin
			pending <= 1'b0;
		end else if (pending) begin
			data_wait <= data_wait - 1'b1;
		end else if (data_req && addr_wait != 2'd0) begin
			addr_wait <= addr_wait - 1'b1;
		end
	end

	// stores land at acceptance and load data is held until data_ok
	always @(posedge clk) begin
		if (data_addr_ok && data_wr) begin
			case (data_size)
				size_byte: mem[idx][8*data_addr[1:0] +: 8] <= data_wdata[8*data_addr[1:0] +: 8];
				size_half: mem[idx][16*data_addr[1] +: 16] <= data_wdata[16*data_addr[1] +: 16];
				default:   mem[idx] <= data_wdata;
			endcase
		end
		if (data_addr_ok && !data_wr) begin
			data_rdata <= mem[idx];
		end
	end

endmodule

`default_nettype wire

// File: bench/data_access_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

module data_access_unit_tb;

	import data_access_pkg::*;

	logic        clk = 1'b0;
	logic        reset = 1'b1;
	logic        cmd_valid;
	mem_cmd_t    cmd;
	logic        cmd_allowin, exc_valid, wb_valid;
	exc_t        exc;
	wb_t         wb;
	logic        data_req, data_wr, data_addr_ok, data_data_ok;
	logic [1:0]  data_size;
	logic [31:0] data_addr, data_wdata, data_rdata;

	// command table with its expected results
	string       t_name[$];
	mem_op_e     t_op[$];
	logic [31:0] t_addr[$], t_wdata[$], exp_value[$];
	logic [4:0]  t_wreg[$];
	int          take_cycle[$];
	int          exc_q[$], wb_q[$];
	logic [31:0] ref_mem [256];
	int          cycle = 0, errors = 0, bus_count = 0, aligned_count = 0;
	logic        load_ok_prev = 1'b0;

	data_access_unit i_data_access_unit (.*);

	sram_data_model i_sram_data_model (.*);

	always #2 clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	////////////////////////////////////////////////////////////////////////////
	// reference rules

	function automatic logic is_store(mem_op_e op);
		return op == op_sb || op == op_sh || op == op_sw;
	endfunction

	function automatic logic is_aligned(mem_op_e op, logic [31:0] addr);
		if (op == op_lw || op == op_sw) return addr[1:0] == 2'b00;
		if (op == op_lh || op == op_lhu || op == op_sh) return !addr[0];
		return 1'b1;
	endfunction

	function automatic logic [31:0] load_value(mem_op_e op, logic [31:0] word, logic [1:0] off);
		logic [7:0]  b;
		logic [15:0] h;
		b = word[8*off +: 8];
		h = off[1] ? word[31:16] : word[15:0];
		case (op)
			op_lb:   return {{24{b[7]}}, b};
			op_lbu:  return {24'd0, b};
			op_lh:   return {{16{h[15]}}, h};
			op_lhu:  return {16'd0, h};
			default: return word;
		endcase
	endfunction

	// stores update the reference memory in table order
	task automatic add_test(string name, mem_op_e op, logic [31:0] addr, logic [31:0] wdata,
			logic [4:0] wreg);
		int n;
		int idx;
		n   = t_op.size();
		idx = addr[9:2];
		t_name.push_back(name);
		t_op.push_back(op);
		t_addr.push_back(addr);
		t_wdata.push_back(wdata);
		t_wreg.push_back(wreg);
		if (!is_aligned(op, addr)) begin
			exc_q.push_back(n);
		end else begin
			aligned_count++;
			case (op)
				op_sb:   ref_mem[idx][8*addr[1:0] +: 8] = wdata[7:0];
				op_sh:   ref_mem[idx][16*addr[1] +: 16] = wdata[15:0];
				op_sw:   ref_mem[idx] = wdata;
				default: wb_q.push_back(n);
			endcase
		end
		exp_value.push_back(load_value(op, ref_mem[idx], addr[1:0]));
	endtask

	task automatic build_table();
		add_test("sw_word",      op_sw,  32'h040, 32'h8badf00d, 5'd0);
		add_test("lw_word",      op_lw,  32'h040, 32'h0,        5'd3);
		add_test("sb_lane1",     op_sb,  32'h081, 32'h000000a5, 5'd0);
		add_test("sh_lane2",     op_sh,  32'h082, 32'h0000c3d4, 5'd0);
		add_test("lw_narrow",    op_lw,  32'h080, 32'h0,        5'd4);
		add_test("sw_signs",     op_sw,  32'h0c0, 32'h80ff7f01, 5'd0);
		add_test("lb_off0",      op_lb,  32'h0c0, 32'h0,        5'd5);
		add_test("lb_off1",      op_lb,  32'h0c1, 32'h0,        5'd6);
		add_test("lb_off2",      op_lb,  32'h0c2, 32'h0,        5'd7);
		add_test("lb_off3",      op_lb,  32'h0c3, 32'h0,        5'd8);
		add_test("lbu_off0",     op_lbu, 32'h0c0, 32'h0,        5'd9);
		add_test("lbu_off1",     op_lbu, 32'h0c1, 32'h0,        5'd10);
		add_test("lbu_off2",     op_lbu, 32'h0c2, 32'h0,        5'd11);
		add_test("lbu_off3",     op_lbu, 32'h0c3, 32'h0,        5'd12);
		add_test("lh_off0",      op_lh,  32'h0c0, 32'h0,        5'd13);
		add_test("lh_off2",      op_lh,  32'h0c2, 32'h0,        5'd14);
		add_test("lhu_off0",     op_lhu, 32'h0c0, 32'h0,        5'd15);
		add_test("lhu_off2",     op_lhu, 32'h0c2, 32'h0,        5'd16);
		add_test("lw_bad",       op_lw,  32'h101, 32'h0,        5'd17);
		add_test("lh_bad",       op_lh,  32'h0c3, 32'h0,        5'd18);
		add_test("sw_bad",       op_sw,  32'h106, 32'hdeadbeef, 5'd19);
		add_test("sh_bad",       op_sh,  32'h0c1, 32'h00001234, 5'd20);
		add_test("lw_after_sh",  op_lw,  32'h0c0, 32'h0,        5'd21);
		add_test("lw_after_sw",  op_lw,  32'h104, 32'h0,        5'd22);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// failure reporting

	task automatic show_mismatch(string name, string what, logic [31:0] expected,
			logic [31:0] actual);
		$display("[ERROR] %s %s: expected %h, actual %h", name, what, expected, actual);
		errors++;
	endtask

	task automatic note_failure(string msg);
		$display("%s", msg);
		errors++;
	endtask

	task automatic finish_run();
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus

	initial begin
		cmd_valid = 1'b0;
		cmd = '0;
		for (int i = 0; i < 256; i++) begin
			ref_mem[i] = i * 32'h01010101;
		end
		build_table();
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		if (data_req !== 1'b0) show_mismatch("reset_values", "data_req", 0, data_req);
		if (wb_valid !== 1'b0) show_mismatch("reset_values", "wb_valid", 0, wb_valid);
		if (exc_valid !== 1'b0) show_mismatch("reset_values", "exc_valid", 0, exc_valid);
		if (cmd_allowin !== 1'b1) show_mismatch("reset_values", "cmd_allowin", 1, cmd_allowin);
		for (int i = 0; i < t_op.size(); i++) begin
			@(posedge clk);
			cmd_valid <= 1'b1;
			cmd <= '{op: t_op[i], addr: t_addr[i], wdata: t_wdata[i], wreg: t_wreg[i]};
			@(negedge clk);
			while (!cmd_allowin) @(negedge clk);
			// taken at the coming rising edge
			take_cycle.push_back(cycle);
		end
		@(posedge clk);
		cmd_valid <= 1'b0;
		while (exc_q.size() != 0 || wb_q.size() != 0) @(negedge clk);
		repeat (8) @(negedge clk);
		if (bus_count != aligned_count)
			show_mismatch("bus", "request count", aligned_count, bus_count);
		finish_run();
	end

	initial begin
		@(posedge clk);
		while (cycle < t_op.size() * 20) @(posedge clk);
		note_failure("timeout: not all expected results arrived in time");
		finish_run();
	end

	////////////////////////////////////////////////////////////////////////////
	// result monitor

	always @(negedge clk) begin
		int        idx;
		exc_code_e exp_code;
		if (!reset) begin
			if (data_req && data_addr_ok) bus_count++;
			if (exc_valid && exc_q.size() == 0) begin
				note_failure("exc_valid pulsed with no misaligned command pending");
			end else if (exc_valid) begin
				idx = exc_q.pop_front();
				exp_code = is_store(t_op[idx]) ? exc_ades : exc_adel;
				if (cycle != take_cycle[idx] + 1)
					note_failure("exc_valid not one cycle after take");
				if (exc.code != exp_code)
					show_mismatch(t_name[idx], "code", exp_code, exc.code);
				if (exc.badvaddr != t_addr[idx])
					show_mismatch(t_name[idx], "badvaddr", t_addr[idx], exc.badvaddr);
				if (exc.wreg != t_wreg[idx])
					show_mismatch(t_name[idx], "exc wreg", t_wreg[idx], exc.wreg);
			end
			if (wb_valid != load_ok_prev)
				note_failure("wb_valid not one cycle after a load data_ok");
			if (wb_valid && wb_q.size() == 0) begin
				note_failure("wb_valid pulsed with no load pending");
			end else if (wb_valid) begin
				idx = wb_q.pop_front();
				if (wb.wreg != t_wreg[idx])
					show_mismatch(t_name[idx], "wb wreg", t_wreg[idx], wb.wreg);
				if (wb.data != exp_value[idx])
					show_mismatch(t_name[idx], "wb data", exp_value[idx], wb.data);
			end
			load_ok_prev = data_data_ok && !data_wr;
		end
	end

endmodule

`default_nettype wire

// File: data_access_unit.f
rtl/data_access_pkg.sv
rtl/mem_op_issue.sv
rtl/mem_req_queue.sv
rtl/sram_data_master.sv
rtl/data_access_unit.sv
bench/sram_data_model.sv
bench/data_access_unit_tb.sv

// File: Bender.yml
package:
  name: data_access_unit

sources:
  - rtl/data_access_pkg.sv
  - rtl/mem_op_issue.sv
  - rtl/mem_req_queue.sv
  - rtl/sram_data_master.sv
  - rtl/data_access_unit.sv
  - target: simulation
    files:
      - bench/sram_data_model.sv
      - bench/data_access_unit_tb.sv
